//--- source/mips_isa_pkg.sv
package mips_isa_pkg;

	// data word and byte address, both 32 bits
	typedef logic [31:0] word_t;

	// index into the general register file
	typedef logic [4:0] reg_idx_t;

	// primary opcode, instruction bits 31..26
	typedef logic [5:0] opcode_t;

	// r-type function field, instruction bits 5..0
	typedef logic [5:0] funct_t;

	// opcodes of the supported subset
	localparam opcode_t op_rtype = 6'b000000;
	localparam opcode_t op_lw = 6'b100011;
	localparam opcode_t op_sw = 6'b101011;
	localparam opcode_t op_beq = 6'b000100;
	localparam opcode_t op_addi = 6'b001000;
	localparam opcode_t op_j = 6'b000010;

	// r-type function codes
	localparam funct_t fn_add = 6'b100000;
	localparam funct_t fn_sub = 6'b100010;
	localparam funct_t fn_and = 6'b100100;
	localparam funct_t fn_or = 6'b100101;
	localparam funct_t fn_slt = 6'b101010;

endpackage

//--- source/mips_ctrl_pkg.sv
package mips_ctrl_pkg;

	// multicycle sequencer states, fetch is the reset state
	typedef enum logic [3:0] {
		fetch,
		decode,
		mem_addr,
		mem_read,
		mem_writeback,
		mem_write,
		execute,
		alu_writeback,
		branch,
		addi_execute,
		addi_writeback,
		jump
	} decoder_state_t;

	// second alu operand
	typedef enum logic [1:0] {
		reg_b = 2'b00,
		four = 2'b01,
		sign_imm = 2'b10,
		sign_imm_x4 = 2'b11
	} alu_src_b_t;

	// next pc source
	typedef enum logic [1:0] {
		alu_result = 2'b00,
		alu_out = 2'b01,
		jump_target = 2'b10
	} pc_src_t;

	// operation class from the sequencer
	typedef enum logic [1:0] {
		aluop_add = 2'b00,
		aluop_sub = 2'b01,
		aluop_funct = 2'b10
	} alu_op_t;

	// function actually carried out by the alu
	typedef enum logic [2:0] {
		func_and = 3'b000,
		func_or = 3'b001,
		func_add = 3'b010,
		func_sub = 3'b110,
		func_slt = 3'b111
	} alu_func_t;

endpackage

//--- source/alu.sv
module alu (
	input mips_isa_pkg::word_t a,
	input mips_isa_pkg::word_t b,
	input mips_ctrl_pkg::alu_op_t alu_op,
	input mips_isa_pkg::funct_t funct,
	output mips_isa_pkg::word_t result,
	output logic zero
);

	mips_ctrl_pkg::alu_func_t func;

	// function decode, the funct field only counts for r-type
	always_comb begin
		case (alu_op)
			mips_ctrl_pkg::aluop_add: func = mips_ctrl_pkg::func_add;
			mips_ctrl_pkg::aluop_sub: func = mips_ctrl_pkg::func_sub;
			default: begin
				case (funct)
					mips_isa_pkg::fn_add: func = mips_ctrl_pkg::func_add;
					mips_isa_pkg::fn_sub: func = mips_ctrl_pkg::func_sub;
					mips_isa_pkg::fn_and: func = mips_ctrl_pkg::func_and;
					mips_isa_pkg::fn_or: func = mips_ctrl_pkg::func_or;
					mips_isa_pkg::fn_slt: func = mips_ctrl_pkg::func_slt;
					// unknown function code behaves as add
					default: func = mips_ctrl_pkg::func_add;
				endcase
			end
		endcase
	end

	// arithmetic and logic
	always_comb begin
		case (func)
			mips_ctrl_pkg::func_and: result = a & b;
			mips_ctrl_pkg::func_or: result = a | b;
			mips_ctrl_pkg::func_sub: result = a - b;
			mips_ctrl_pkg::func_slt: begin
				// signed compare, result is 0 or 1
				result = {31'd0, $signed(a) < $signed(b)};
			end
			default: result = a + b;
		endcase
	end

	// beq uses this after a subtract
	assign zero = (result == '0);

endmodule

//--- source/register_file.sv
module register_file (
	input logic clk,
	input logic write_enable,
	input mips_isa_pkg::reg_idx_t read_addr_1,
	input mips_isa_pkg::reg_idx_t read_addr_2,
	input mips_isa_pkg::reg_idx_t write_addr,
	input mips_isa_pkg::word_t write_data,
	output mips_isa_pkg::word_t read_data_1,
	output mips_isa_pkg::word_t read_data_2
);

	mips_isa_pkg::word_t regs [32];

	// write port, $zero is never stored
	always_ff @(posedge clk) begin
		if (write_enable && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end

	// combinational reads, $zero is hardwired
	assign read_data_1 = (read_addr_1 == '0) ? '0 : regs[read_addr_1];
	assign read_data_2 = (read_addr_2 == '0) ? '0 : regs[read_addr_2];

	// an unknown value written here would poison later stores
	assert property (@(posedge clk) write_enable |-> !$isunknown(write_data));

endmodule

//--- source/main_decoder.sv
module main_decoder (
	input logic clk,
	input logic reset,
	input mips_isa_pkg::opcode_t opcode,
	output logic mem_write,
	output logic iord,
	output logic ir_write,
	output logic reg_dst,
	output logic mem_to_reg,
	output logic reg_write,
	output logic alu_src_a,
	output mips_ctrl_pkg::alu_src_b_t alu_src_b,
	output mips_ctrl_pkg::pc_src_t pc_src,
	output mips_ctrl_pkg::alu_op_t alu_op,
	output logic branch,
	output logic pc_write
);

	mips_ctrl_pkg::decoder_state_t state;
	mips_ctrl_pkg::decoder_state_t state_next;

	// state register
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= mips_ctrl_pkg::fetch;
		end else begin
			state <= state_next;
		end
	end

	// next state
	always_comb begin
		// single-cycle tail states fall back to fetch
		state_next = mips_ctrl_pkg::fetch;
		case (state)
			mips_ctrl_pkg::fetch: state_next = mips_ctrl_pkg::decode;
			mips_ctrl_pkg::decode: begin
				case (opcode)
					mips_isa_pkg::op_rtype: state_next = mips_ctrl_pkg::execute;
					mips_isa_pkg::op_lw: state_next = mips_ctrl_pkg::mem_addr;
					mips_isa_pkg::op_sw: state_next = mips_ctrl_pkg::mem_addr;
					mips_isa_pkg::op_beq: state_next = mips_ctrl_pkg::branch;
					mips_isa_pkg::op_addi: state_next = mips_ctrl_pkg::addi_execute;
					mips_isa_pkg::op_j: state_next = mips_ctrl_pkg::jump;
					// unknown opcode is a no-op, straight back to fetch
					default: state_next = mips_ctrl_pkg::fetch;
				endcase
			end
			mips_ctrl_pkg::mem_addr: begin
				// address is ready, split load from store
				if (opcode == mips_isa_pkg::op_lw) begin
					state_next = mips_ctrl_pkg::mem_read;
				end else begin
					state_next = mips_ctrl_pkg::mem_write;
				end
			end
			mips_ctrl_pkg::mem_read: state_next = mips_ctrl_pkg::mem_writeback;
			mips_ctrl_pkg::execute: state_next = mips_ctrl_pkg::alu_writeback;
			mips_ctrl_pkg::addi_execute: state_next = mips_ctrl_pkg::addi_writeback;
			default: state_next = mips_ctrl_pkg::fetch;
		endcase
	end

	// per-state strobes, everything idle unless a state raises it
	always_comb begin
		mem_write = 1'b0;
		iord = 1'b0;
		ir_write = 1'b0;
		reg_dst = 1'b0;
		mem_to_reg = 1'b0;
		reg_write = 1'b0;
		alu_src_a = 1'b0;
		alu_src_b = mips_ctrl_pkg::reg_b;
		pc_src = mips_ctrl_pkg::alu_result;
		alu_op = mips_ctrl_pkg::aluop_add;
		branch = 1'b0;
		pc_write = 1'b0;
		case (state)
			mips_ctrl_pkg::fetch: begin
				// latch instruction, pc <= pc + 4
				ir_write = 1'b1;
				alu_src_b = mips_ctrl_pkg::four;
				pc_write = 1'b1;
			end
			mips_ctrl_pkg::decode: begin
				// speculative branch target into the alu-result register
				alu_src_b = mips_ctrl_pkg::sign_imm_x4;
			end
			mips_ctrl_pkg::mem_addr, mips_ctrl_pkg::addi_execute: begin
				alu_src_a = 1'b1;
				alu_src_b = mips_ctrl_pkg::sign_imm;
			end
			mips_ctrl_pkg::mem_read: iord = 1'b1;
			mips_ctrl_pkg::mem_writeback: begin
				mem_to_reg = 1'b1;
				reg_write = 1'b1;
			end
			mips_ctrl_pkg::mem_write: begin
				mem_write = 1'b1;
				iord = 1'b1;
			end
			mips_ctrl_pkg::execute: begin
				alu_src_a = 1'b1;
				alu_op = mips_ctrl_pkg::aluop_funct;
			end
			mips_ctrl_pkg::alu_writeback: begin
				// r-type result goes to rd
				reg_dst = 1'b1;
				reg_write = 1'b1;
			end
			mips_ctrl_pkg::branch: begin
				// compare a and b, pc takes the target only on zero
				alu_src_a = 1'b1;
				alu_op = mips_ctrl_pkg::aluop_sub;
				pc_src = mips_ctrl_pkg::alu_out;
				branch = 1'b1;
			end
			mips_ctrl_pkg::addi_writeback: reg_write = 1'b1;
			mips_ctrl_pkg::jump: begin
				pc_src = mips_ctrl_pkg::jump_target;
				pc_write = 1'b1;
			end
			default: ;
		endcase
	end

	// sequencer never leaves the twelve legal states
	assert property (@(posedge clk) disable iff (reset)
		state inside {[mips_ctrl_pkg::fetch : mips_ctrl_pkg::jump]});

	// a store and a register write never share a cycle
	assert property (@(posedge clk) disable iff (reset) !(mem_write && reg_write));

	// the instruction register is only refreshed on a fetch
	assert property (@(posedge clk) disable iff (reset)
		ir_write |-> state == mips_ctrl_pkg::fetch);

endmodule

//--- source/datapath.sv
module datapath #(
	parameter mips_isa_pkg::word_t reset_pc = '0
) (
	input logic clk,
	input logic reset,
	input logic iord,
	input logic ir_write,
	input logic reg_dst,
	input logic mem_to_reg,
	input logic reg_write,
	input logic alu_src_a,
	input mips_ctrl_pkg::alu_src_b_t alu_src_b,
	input mips_ctrl_pkg::pc_src_t pc_src,
	input mips_ctrl_pkg::alu_op_t alu_op,
	input logic branch,
	input logic pc_write,
	input mips_isa_pkg::word_t mem_rdata,
	output mips_isa_pkg::opcode_t opcode,
	output mips_isa_pkg::word_t mem_addr,
	output mips_isa_pkg::word_t mem_wdata
);

	// architectural and holding registers
	mips_isa_pkg::word_t pc;
	mips_isa_pkg::word_t instr;
	mips_isa_pkg::word_t data_reg;
	mips_isa_pkg::word_t a_reg;
	mips_isa_pkg::word_t b_reg;
	mips_isa_pkg::word_t alu_out;

	mips_isa_pkg::word_t pc_next;
	mips_isa_pkg::word_t rd_data_1;
	mips_isa_pkg::word_t rd_data_2;
	mips_isa_pkg::word_t src_a;
	mips_isa_pkg::word_t src_b;
	mips_isa_pkg::word_t alu_result;
	mips_isa_pkg::word_t sign_imm;
	mips_isa_pkg::word_t sign_imm_x4;
	mips_isa_pkg::word_t jump_target;
	mips_isa_pkg::word_t wr_data;
	mips_isa_pkg::reg_idx_t rs;
	mips_isa_pkg::reg_idx_t rt;
	mips_isa_pkg::reg_idx_t rd;
	mips_isa_pkg::reg_idx_t wr_addr;
	mips_isa_pkg::funct_t funct;
	logic alu_zero;
	logic pc_en;

	// instruction fields
	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign funct = instr[5:0];

	// immediates and jump target, pc already points past the instruction
	assign sign_imm = {{16{instr[15]}}, instr[15:0]};
	assign sign_imm_x4 = {sign_imm[29:0], 2'b00};
	assign jump_target = {pc[31:28], instr[25:0], 2'b00};

	// taken beq loads the pc too
	assign pc_en = pc_write | (branch & alu_zero);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= reset_pc;
		end else if (pc_en) begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (ir_write) begin
			instr <= mem_rdata;
		end
	end

	// holding registers refresh every cycle
	always_ff @(posedge clk) begin
		data_reg <= mem_rdata;
		a_reg <= rd_data_1;
		b_reg <= rd_data_2;
		alu_out <= alu_result;
	end

	// write-back target and data
	assign wr_addr = reg_dst ? rd : rt;
	assign wr_data = mem_to_reg ? data_reg : alu_out;

	register_file i_register_file (
		.clk(clk),
		.write_enable(reg_write),
		.read_addr_1(rs),
		.read_addr_2(rt),
		.write_addr(wr_addr),
		.write_data(wr_data),
		.read_data_1(rd_data_1),
		.read_data_2(rd_data_2)
	);

	// alu operands
	assign src_a = alu_src_a ? a_reg : pc;

	always_comb begin
		case (alu_src_b)
			mips_ctrl_pkg::four: src_b = 32'd4;
			mips_ctrl_pkg::sign_imm: src_b = sign_imm;
			mips_ctrl_pkg::sign_imm_x4: src_b = sign_imm_x4;
			default: src_b = b_reg;
		endcase
	end

	alu i_alu (
		.a(src_a),
		.b(src_b),
		.alu_op(alu_op),
		.funct(funct),
		.result(alu_result),
		.zero(alu_zero)
	);

	// next pc
	always_comb begin
		case (pc_src)
			mips_ctrl_pkg::alu_out: pc_next = alu_out;
			mips_ctrl_pkg::jump_target: pc_next = jump_target;
			default: pc_next = alu_result;
		endcase
	end

	// fetch from pc, data access through the alu-result register
	assign mem_addr = iord ? alu_out : pc;
	assign mem_wdata = b_reg;

	// every pc source keeps word alignment
	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

//--- source/mips_multicycle.sv
module mips_multicycle #(
	parameter mips_isa_pkg::word_t reset_pc = '0
) (
	input logic clk,
	input logic reset,
	input mips_isa_pkg::word_t mem_rdata,
	output mips_isa_pkg::word_t mem_addr,
	output mips_isa_pkg::word_t mem_wdata,
	output logic mem_write
);

	// decoder to datapath strobes
	mips_isa_pkg::opcode_t opcode;
	logic iord;
	logic ir_write;
	logic reg_dst;
	logic mem_to_reg;
	logic reg_write;
	logic alu_src_a;
	mips_ctrl_pkg::alu_src_b_t alu_src_b;
	mips_ctrl_pkg::pc_src_t pc_src;
	mips_ctrl_pkg::alu_op_t alu_op;
	logic branch;
	logic pc_write;

	// store strobe goes straight out to memory
	main_decoder i_main_decoder (
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.mem_write(mem_write),
		.iord(iord),
		.ir_write(ir_write),
		.reg_dst(reg_dst),
		.mem_to_reg(mem_to_reg),
		.reg_write(reg_write),
		.alu_src_a(alu_src_a),
		.alu_src_b(alu_src_b),
		.pc_src(pc_src),
		.alu_op(alu_op),
		.branch(branch),
		.pc_write(pc_write)
	);

	datapath #(
		.reset_pc(reset_pc)
	) i_datapath (
		.clk(clk),
		.reset(reset),
		.iord(iord),
		.ir_write(ir_write),
		.reg_dst(reg_dst),
		.mem_to_reg(mem_to_reg),
		.reg_write(reg_write),
		.alu_src_a(alu_src_a),
		.alu_src_b(alu_src_b),
		.pc_src(pc_src),
		.alu_op(alu_op),
		.branch(branch),
		.pc_write(pc_write),
		.mem_rdata(mem_rdata),
		.opcode(opcode),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

endmodule

//--- tb/tb_mips_multicycle.sv
module tb_mips_multicycle;

	localparam mips_isa_pkg::word_t reset_pc = '0;
	localparam int num_tests = 4;
	localparam int words_per_test = 4;

	logic clk;
	logic reset;
	mips_isa_pkg::word_t mem_rdata;
	mips_isa_pkg::word_t mem_addr;
	mips_isa_pkg::word_t mem_wdata;
	logic mem_write;

	// unified memory and the image each test starts from
	mips_isa_pkg::word_t mem [256];
	mips_isa_pkg::word_t prog_mem [256];
	mips_isa_pkg::word_t data_words [num_tests][words_per_test];
	int wr_ptr;

	// expected stores and halt point from the reference model
	mips_isa_pkg::word_t exp_addr [$];
	mips_isa_pkg::word_t exp_data [$];
	int exp_cycle [$];
	mips_isa_pkg::word_t halt_pc;

	int cycle;
	int store_idx;
	int error_count;
	int check_count;
	int failed_tests;
	int current_test;
	int limit_cycles;
	integer seed;

	mips_multicycle #(
		.reset_pc(reset_pc)
	) i_mips_multicycle (
		.clk(clk),
		.reset(reset),
		.mem_rdata(mem_rdata),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_write(mem_write)
	);

	always #5 clk = ~clk;

	// word-addressed combinational read
	assign mem_rdata = mem[mem_addr[9:2]];

	always @(posedge clk) begin
		if (mem_write) begin
			mem[mem_addr[9:2]] <= mem_wdata;
		end
	end

	// cycle 0 is the first fetch after reset
	always @(posedge clk or posedge reset) begin
		if (reset) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
		end
	end

	task automatic check_value(input string what, input logic [63:0] actual,
		input logic [63:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	function automatic string test_name(input int t);
		case (t)
			0: return "rtype";
			1: return "load_store";
			2: return "branch";
			default: return "jump_nop";
		endcase
	endfunction

	// instruction encoders
	function automatic mips_isa_pkg::word_t rtype_word(input mips_isa_pkg::reg_idx_t rd,
		input mips_isa_pkg::reg_idx_t rs, input mips_isa_pkg::reg_idx_t rt,
		input mips_isa_pkg::funct_t fn);
		return {mips_isa_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic mips_isa_pkg::word_t itype_word(input mips_isa_pkg::opcode_t op,
		input mips_isa_pkg::reg_idx_t rs, input mips_isa_pkg::reg_idx_t rt, input int imm);
		return {op, rs, rt, imm[15:0]};
	endfunction

	function automatic mips_isa_pkg::word_t jump_word(input int index);
		return {mips_isa_pkg::op_j, index[25:0]};
	endfunction

	task automatic emit(input mips_isa_pkg::word_t w);
		prog_mem[wr_ptr] = w;
		wr_ptr++;
	endtask

	// memory image for test t with its operands at 0x100
	task automatic build_program(input int t);
		int loop_top;
		for (int i = 0; i < 256; i++) begin
			prog_mem[i] = 32'h5a00_0000 | (i * 32'h0001_0101);
		end
		for (int k = 0; k < words_per_test; k++) begin
			prog_mem[64 + k] = data_words[t][k];
		end
		wr_ptr = reset_pc[9:2];
		case (t)
			0: begin
				emit(itype_word(mips_isa_pkg::op_lw, 0, 1, 'h100));
				emit(itype_word(mips_isa_pkg::op_lw, 0, 2, 'h104));
				emit(rtype_word(3, 1, 2, mips_isa_pkg::fn_add));
				emit(itype_word(mips_isa_pkg::op_sw, 0, 3, 'h180));
				emit(rtype_word(4, 1, 2, mips_isa_pkg::fn_sub));
				emit(itype_word(mips_isa_pkg::op_sw, 0, 4, 'h184));
				emit(rtype_word(5, 1, 2, mips_isa_pkg::fn_and));
				emit(itype_word(mips_isa_pkg::op_sw, 0, 5, 'h188));
				emit(rtype_word(6, 1, 2, mips_isa_pkg::fn_or));
				emit(itype_word(mips_isa_pkg::op_sw, 0, 6, 'h18c));
				emit(rtype_word(7, 1, 2, mips_isa_pkg::fn_slt));
				emit(itype_word(mips_isa_pkg::op_sw, 0, 7, 'h190));
				emit(rtype_word(8, 2, 1, mips_isa_pkg::fn_slt));
				emit(itype_word(mips_isa_pkg::op_sw, 0, 8, 'h194));
			end
			1: begin
				// base pointer built with a negative immediate
				emit(itype_word(mips_isa_pkg::op_addi, 0, 10, 'h1c0));
				emit(itype_word(mips_isa_pkg::op_addi, 10, 10, -16));
				emit(itype_word(mips_isa_pkg::op_lw, 0, 1, 'h100));
				emit(itype_word(mips_isa_pkg::op_sw, 10, 1, 0));
				emit(itype_word(mips_isa_pkg::op_lw, 0, 2, 'h104));
				emit(itype_word(mips_isa_pkg::op_sw, 10, 2, -4));
				emit(itype_word(mips_isa_pkg::op_addi, 0, 11, -8));
				// 0x110 + (-8) lands on the third operand
				emit(itype_word(mips_isa_pkg::op_lw, 11, 3, 'h110));
				emit(itype_word(mips_isa_pkg::op_sw, 10, 3, 4));
				emit(itype_word(mips_isa_pkg::op_sw, 10, 11, 8));
			end
			2: begin
				emit(itype_word(mips_isa_pkg::op_lw, 0, 4, 'h100));
				emit(itype_word(mips_isa_pkg::op_addi, 0, 1, 3));
				emit(itype_word(mips_isa_pkg::op_addi, 0, 2, 5));
				// not taken and then taken over one store
				emit(itype_word(mips_isa_pkg::op_beq, 1, 2, 1));
				emit(itype_word(mips_isa_pkg::op_sw, 0, 1, 'h180));
				emit(itype_word(mips_isa_pkg::op_beq, 1, 1, 1));
				emit(itype_word(mips_isa_pkg::op_sw, 0, 2, 'h184));
				emit(itype_word(mips_isa_pkg::op_addi, 0, 3, 'h1c0));
				// count $1 down to zero with one store per pass
				loop_top = wr_ptr;
				emit(itype_word(mips_isa_pkg::op_sw, 3, 4, 0));
				emit(rtype_word(4, 4, 1, mips_isa_pkg::fn_add));
				emit(itype_word(mips_isa_pkg::op_addi, 3, 3, 4));
				emit(itype_word(mips_isa_pkg::op_addi, 1, 1, -1));
				emit(itype_word(mips_isa_pkg::op_beq, 1, 0, 1));
				emit(itype_word(mips_isa_pkg::op_beq, 0, 0, loop_top - (wr_ptr + 1)));
				emit(itype_word(mips_isa_pkg::op_sw, 3, 3, 0));
			end
			default: begin
				emit(itype_word(mips_isa_pkg::op_lw, 0, 1, 'h100));
				emit(jump_word(wr_ptr + 2));
				emit(itype_word(mips_isa_pkg::op_sw, 0, 1, 'h180));
				// ori is outside the subset so $1 must survive it
				emit(itype_word(6'b001101, 0, 1, 'hffff));
				emit(itype_word(mips_isa_pkg::op_addi, 0, 0, 'h123));
				emit(rtype_word(0, 1, 1, mips_isa_pkg::fn_add));
				emit(itype_word(mips_isa_pkg::op_lw, 0, 0, 'h104));
				emit(itype_word(mips_isa_pkg::op_sw, 0, 0, 'h184));
				emit(itype_word(mips_isa_pkg::op_sw, 0, 1, 'h188));
			end
		endcase
		// halt is a jump to itself
		emit(jump_word(wr_ptr));
	endtask

	// instruction-set model that returns the cycle where the halt fetch starts
	function automatic int run_reference();
		mips_isa_pkg::word_t regs [32];
		mips_isa_pkg::word_t dmem [256];
		mips_isa_pkg::word_t pc;
		mips_isa_pkg::word_t pc_plus;
		mips_isa_pkg::word_t instr;
		mips_isa_pkg::word_t imm;
		mips_isa_pkg::word_t addr;
		mips_isa_pkg::word_t res;
		mips_isa_pkg::reg_idx_t rs;
		mips_isa_pkg::reg_idx_t rt;
		mips_isa_pkg::reg_idx_t rd;
		int cyc;
		exp_addr.delete();
		exp_data.delete();
		exp_cycle.delete();
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i] = prog_mem[i];
		end
		pc = reset_pc;
		cyc = 0;
		for (int step = 0; step < 1000; step++) begin
			instr = dmem[pc[9:2]];
			rs = instr[25:21];
			rt = instr[20:16];
			rd = instr[15:11];
			imm = {{16{instr[15]}}, instr[15:0]};
			addr = regs[rs] + imm;
			pc_plus = pc + 4;
			if (instr[31:26] == mips_isa_pkg::op_j
				&& {pc_plus[31:28], instr[25:0], 2'b00} == pc) begin
				halt_pc = pc;
				return cyc;
			end
			case (instr[31:26])
				mips_isa_pkg::op_rtype: begin
					case (instr[5:0])
						mips_isa_pkg::fn_sub: res = regs[rs] - regs[rt];
						mips_isa_pkg::fn_and: res = regs[rs] & regs[rt];
						mips_isa_pkg::fn_or: res = regs[rs] | regs[rt];
						mips_isa_pkg::fn_slt: res = ($signed(regs[rs]) < $signed(regs[rt])) ? 1 : 0;
						default: res = regs[rs] + regs[rt];
					endcase
					if (rd != 0) begin
						regs[rd] = res;
					end
					cyc += 4;
				end
				mips_isa_pkg::op_lw: begin
					if (rt != 0) begin
						regs[rt] = dmem[addr[9:2]];
					end
					cyc += 5;
				end
				mips_isa_pkg::op_sw: begin
					// the store strobe sits in the fourth cycle
					exp_addr.push_back(addr);
					exp_data.push_back(regs[rt]);
					exp_cycle.push_back(cyc + 3);
					dmem[addr[9:2]] = regs[rt];
					cyc += 4;
				end
				mips_isa_pkg::op_addi: begin
					if (rt != 0) begin
						regs[rt] = addr;
					end
					cyc += 4;
				end
				mips_isa_pkg::op_beq: begin
					if (regs[rs] == regs[rt]) begin
						pc_plus = pc_plus + {imm[29:0], 2'b00};
					end
					cyc += 3;
				end
				mips_isa_pkg::op_j: begin
					pc_plus = {pc_plus[31:28], instr[25:0], 2'b00};
					cyc += 3;
				end
				// anything else decodes as a no-op
				default: cyc += 2;
			endcase
			pc = pc_plus;
		end
		halt_pc = pc;
		return cyc;
	endfunction

	// every store is matched against the next expected one
	always @(negedge clk) begin
		if (!reset && mem_write) begin
			if (store_idx < exp_addr.size()) begin
				check_value("store address", mem_addr, exp_addr[store_idx]);
				check_value("store data", mem_wdata, exp_data[store_idx]);
				check_value("store cycle", cycle, exp_cycle[store_idx]);
			end else begin
				check_value("store count", store_idx + 1, exp_addr.size());
			end
			store_idx++;
		end
	end

	task automatic run_test(input int t);
		int halt_cycle;
		int errors_before;
		bit done;
		current_test = t;
		errors_before = error_count;
		@(posedge clk);
		#1 reset = 1'b1;
		build_program(t);
		halt_cycle = run_reference();
		for (int i = 0; i < 256; i++) begin
			mem[i] = prog_mem[i];
		end
		store_idx = 0;
		// four reset cycles with no store and the pc parked at its reset value
		repeat (4) begin
			@(negedge clk);
			check_value("mem_write in reset", mem_write, 0);
			check_value("mem_addr in reset", mem_addr, reset_pc);
			@(posedge clk);
		end
		#1 reset = 1'b0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (cycle == 0) begin
				check_value("first fetch address", mem_addr, reset_pc);
			end
			if (cycle == halt_cycle) begin
				check_value("halt fetch address", mem_addr, halt_pc);
			end
			if (cycle >= halt_cycle + 6 && store_idx >= exp_addr.size()) begin
				done = 1'b1;
			end
		end
		check_value("store count", store_idx, exp_addr.size());
		if (error_count == errors_before) begin
			$display("test %0d %s: ok, %0d stores", t, test_name(t), store_idx);
		end else begin
			failed_tests++;
			$display("test %0d %s: FAILED with %0d errors", t, test_name(t),
				error_count - errors_before);
		end
	endtask

	// watchdog with a budget from the reference cycle counts
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: test %0d (%s) never finished its stores and reached its halt loop",
			current_test, test_name(current_test));
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int total;
		clk = 1'b0;
		reset = 1'b1;
		seed = 55238;
		error_count = 0;
		check_count = 0;
		failed_tests = 0;
		store_idx = 0;
		current_test = 0;
		for (int t = 0; t < num_tests; t++) begin
			for (int k = 0; k < words_per_test; k++) begin
				data_words[t][k] = $random(seed);
			end
		end
		// reset, sync and tail cycles on top of each program's length
		total = 0;
		for (int t = 0; t < num_tests; t++) begin
			build_program(t);
			total += 4 + 2 + run_reference() + 8;
		end
		limit_cycles = total + 50;
		// memory holds a known image from time zero
		for (int i = 0; i < 256; i++) begin
			mem[i] = prog_mem[i];
		end
		for (int t = 0; t < num_tests; t++) begin
			run_test(t);
		end
		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			num_tests, failed_tests, check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- flist.f
source/mips_isa_pkg.sv
source/mips_ctrl_pkg.sv
source/alu.sv
source/register_file.sv
source/main_decoder.sv
source/datapath.sv
source/mips_multicycle.sv
tb/tb_mips_multicycle.sv

//--- Bender.yml
package:
  name: mips_multicycle

sources:
  - source/mips_isa_pkg.sv
  - source/mips_ctrl_pkg.sv
  - source/alu.sv
  - source/register_file.sv
  - source/main_decoder.sv
  - source/datapath.sv
  - source/mips_multicycle.sv
  - target: test
    files:
      - tb/tb_mips_multicycle.sv
